/* common/soc_settings.svh */
/*
 * soc data side settings
 * bus widths, data memory depth, address map and gpio layout
 */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

//////////////////////////////////////////
// data bus
//////////////////////////////////////////

// byte address width
`define SOC_DAW 15
// data width and number of byte enables
`define SOC_DDW 32
`define SOC_DBW 4

// data memory word address, 4096 words in the lower half
`define SOC_MEM_AW 12

//////////////////////////////////////////
// address map
//////////////////////////////////////////

// set for the peripheral half
`define SOC_PER_BIT 14
// inside the peripheral window, set for the unmapped error region
`define SOC_GPIO_BIT 6

// gpio width and register byte offsets
`define SOC_GW 32
`define SOC_GPIO_OFS_OUT 'h0
`define SOC_GPIO_OFS_OE 'h4
`define SOC_GPIO_OFS_IN 'h8

`endif

/* common/soc_pkg.sv */
/*
 * soc package
 * enums for bus targets and gpio registers
 */
package soc_pkg;

  // block answering a request
  typedef enum logic [1:0] {
    // data memory, lower half
    TGT_MEM  = 2'd0,
    // gpio controller, lower part of the peripheral window
    TGT_GPIO = 2'd1,
    // unmapped region, error response
    TGT_NONE = 2'd2
  } soc_target_e;

  // gpio register picked by the request offset
  typedef enum logic [1:0] {
    // output value
    REG_OUT  = 2'd0,
    // output enable
    REG_OE   = 2'd1,
    // synchronized pin input, read only
    REG_IN   = 2'd2,
    // any other offset
    REG_NONE = 2'd3
  } gpio_reg_e;

endpackage : soc_pkg

/* hdl/bus_decoder.sv */
/*
 * bus decoder
 * splits each request between data memory, gpio and the error region
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_decoder import soc_pkg::*; (
  // incoming request
  input  logic                bus_vld,
  input  logic [`SOC_DAW-1:0] bus_adr,
  // one cycle strobes per target
  output logic                mem_req,
  output logic                gpio_req,
  // target of the current request
  output soc_target_e         target
);

  // peripheral half of the space
  logic per_sel;
  // error region inside the peripheral window
  logic err_sel;

  assign per_sel = bus_adr[`SOC_PER_BIT];
  assign err_sel = bus_adr[`SOC_GPIO_BIT];

  //////////////////////////////////////////
  // address map
  //////////////////////////////////////////

  always_comb begin
    if (!per_sel) begin
      target = TGT_MEM;
    end else if (!err_sel) begin
      target = TGT_GPIO;
    end else begin
      // former uart space
      target = TGT_NONE;
    end
  end

  //////////////////////////////////////////
  // strobes
  //////////////////////////////////////////

  // qualified with bus_vld here only
  assign mem_req  = bus_vld && (target == TGT_MEM);
  assign gpio_req = bus_vld && (target == TGT_GPIO);

  // nothing is strobed for TGT_NONE
  // rsp_mux answers it from the registered target

endmodule : bus_decoder

/* mem/data_mem.sv */
/*
 * data memory
 * single port ram, byte write enables, one cycle synchronous read
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module data_mem import soc_pkg::*; (
  input  logic                   clk,
  // strobe from the decoder
  input  logic                   mem_req,
  input  logic                   bus_wen,
  // word address, byte bits already dropped
  input  logic [`SOC_MEM_AW-1:0] word_adr,
  input  logic [`SOC_DBW-1:0]    bus_ben,
  input  logic [`SOC_DDW-1:0]    bus_wdt,
  // read data, one cycle after mem_req
  output logic [`SOC_DDW-1:0]    mem_rdt
);

  // storage array
  logic [`SOC_DDW-1:0] mem [2**`SOC_MEM_AW];

  //////////////////////////////////////////
  // write port
  //////////////////////////////////////////

  // only the enabled byte lanes change
  always_ff @(posedge clk) begin
    if (mem_req && bus_wen) begin
      for (int i = 0; i < `SOC_DBW; i++) begin
        if (bus_ben[i]) begin
          mem[word_adr][8*i +: 8] <= bus_wdt[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////
  // read port
  //////////////////////////////////////////

  // zero after a write, last value held when idle
  always_ff @(posedge clk) begin
    if (mem_req) begin
      if (bus_wen) begin
        mem_rdt <= '0;
      end else begin
        mem_rdt <= mem[word_adr];
      end
    end
  end

endmodule : data_mem

/* gpio/gpio_ctrl.sv */
/*
 * gpio controller
 * output and enable registers, synchronized pin input, registered reads
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module gpio_ctrl import soc_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  // strobe from the decoder
  input  logic                     gpio_req,
  input  logic                     bus_wen,
  // byte offset inside the gpio region
  input  logic [`SOC_GPIO_BIT-1:0] reg_ofs,
  input  logic [`SOC_DBW-1:0]      bus_ben,
  input  logic [`SOC_DDW-1:0]      bus_wdt,
  // read data, one cycle after gpio_req
  output logic [`SOC_DDW-1:0]      gpio_rdt,
  // pins
  output logic [`SOC_GW-1:0]       gpio_drive,
  output logic [`SOC_GW-1:0]       gpio_oe,
  input  logic [`SOC_GW-1:0]       gpio_pin
);

  // word offset, byte bits dropped
  logic [`SOC_GPIO_BIT-3:0] ofs_word;
  gpio_reg_e                reg_sel;
  // per register write strobes
  logic                     out_we;
  logic                     oe_we;
  // two flop synchronizer
  logic [`SOC_GW-1:0]       pin_meta;
  logic [`SOC_GW-1:0]       pin_sync;

  //////////////////////////////////////////
  // register decode
  //////////////////////////////////////////

  assign ofs_word = reg_ofs[`SOC_GPIO_BIT-1:2];

  always_comb begin
    if (ofs_word == (`SOC_GPIO_BIT-2)'(`SOC_GPIO_OFS_OUT / 4)) begin
      reg_sel = REG_OUT;
    end else if (ofs_word == (`SOC_GPIO_BIT-2)'(`SOC_GPIO_OFS_OE / 4)) begin
      reg_sel = REG_OE;
    end else if (ofs_word == (`SOC_GPIO_BIT-2)'(`SOC_GPIO_OFS_IN / 4)) begin
      reg_sel = REG_IN;
    end else begin
      reg_sel = REG_NONE;
    end
  end

  // writes to REG_IN and REG_NONE fall through
  assign out_we = gpio_req && bus_wen && (reg_sel == REG_OUT);
  assign oe_we  = gpio_req && bus_wen && (reg_sel == REG_OE);

  //////////////////////////////////////////
  // output and enable registers
  //////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_drive <= '0;
      gpio_oe    <= '0;
    end else begin
      // byte by byte update
      for (int i = 0; i < `SOC_DBW; i++) begin
        if (out_we && bus_ben[i]) begin
          gpio_drive[8*i +: 8] <= bus_wdt[8*i +: 8];
        end
        if (oe_we && bus_ben[i]) begin
          gpio_oe[8*i +: 8] <= bus_wdt[8*i +: 8];
        end
      end
    end
  end

  // pin input, visible after two edges
  always_ff @(posedge clk) begin
    pin_meta <= gpio_pin;
    pin_sync <= pin_meta;
  end

  // read data register, zero after writes
  always_ff @(posedge clk) begin
    if (gpio_req) begin
      if (bus_wen) begin
        gpio_rdt <= '0;
      end else begin
        case (reg_sel)
          REG_OUT: gpio_rdt <= gpio_drive;
          REG_OE:  gpio_rdt <= gpio_oe;
          REG_IN:  gpio_rdt <= pin_sync;
          default: gpio_rdt <= '0;
        endcase
      end
    end
  end

endmodule : gpio_ctrl

/* hdl/rsp_mux.sv */
/*
 * response mux
 * registers target and valid, then selects read data and error flag
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module rsp_mux import soc_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // request side, same edge as the targets
  input  logic                bus_vld,
  input  logic                bus_wen,
  input  soc_target_e         target,
  // target read data, already registered
  input  logic [`SOC_DDW-1:0] mem_rdt,
  input  logic [`SOC_DDW-1:0] gpio_rdt,
  // response to the master
  output logic                bus_rsp_vld,
  output logic [`SOC_DDW-1:0] bus_rdt,
  output logic                bus_err
);

  // response pending in this cycle
  logic        vld_q;
  // request kind and target of that response
  logic        wen_q;
  soc_target_e tgt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= bus_vld;
    end
  end

  always_ff @(posedge clk) begin
    wen_q <= bus_wen;
    tgt_q <= target;
  end

  //////////////////////////////////////////
  // response
  //////////////////////////////////////////

  assign bus_rsp_vld = vld_q;
  assign bus_err     = vld_q && (tgt_q == TGT_NONE);

  // writes never carry data, error writes included
  always_comb begin
    bus_rdt = '0;
    if (vld_q && !wen_q) begin
      case (tgt_q)
        TGT_MEM:  bus_rdt = mem_rdt;
        TGT_GPIO: bus_rdt = gpio_rdt;
        default:  bus_rdt = '0;
      endcase
    end
  end

endmodule : rsp_mux

/* hdl/soc_top.sv */
/*
 * soc data side top
 * bus decoder, data memory, gpio controller and response mux
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top import soc_pkg::*; (
  // system
  input  logic                clk,
  input  logic                rst_n,
  // request from the external master
  input  logic                bus_vld,
  input  logic                bus_wen,
  input  logic [`SOC_DAW-1:0] bus_adr,
  input  logic [`SOC_DBW-1:0] bus_ben,
  input  logic [`SOC_DDW-1:0] bus_wdt,
  // response, one cycle after the request
  output logic                bus_rsp_vld,
  output logic [`SOC_DDW-1:0] bus_rdt,
  output logic                bus_err,
  // gpio pins
  output logic [`SOC_GW-1:0]  gpio_drive,
  output logic [`SOC_GW-1:0]  gpio_oe,
  input  logic [`SOC_GW-1:0]  gpio_pin
);

  // per target strobes
  logic                mem_req;
  logic                gpio_req;
  // target of the current request
  soc_target_e         target;
  // registered read data of each target
  logic [`SOC_DDW-1:0] mem_rdt;
  logic [`SOC_DDW-1:0] gpio_rdt;

  //////////////////////////////////////////
  // input side
  //////////////////////////////////////////

  bus_decoder bus_decoder_i (
    .bus_vld  (bus_vld),
    .bus_adr  (bus_adr),
    .mem_req  (mem_req),
    .gpio_req (gpio_req),
    .target   (target)
  );

  //////////////////////////////////////////
  // targets
  //////////////////////////////////////////

  // word address above the byte bits
  data_mem data_mem_i (
    .clk      (clk),
    .mem_req  (mem_req),
    .bus_wen  (bus_wen),
    .word_adr (bus_adr[`SOC_MEM_AW+$clog2(`SOC_DBW)-1:$clog2(`SOC_DBW)]),
    .bus_ben  (bus_ben),
    .bus_wdt  (bus_wdt),
    .mem_rdt  (mem_rdt)
  );

  gpio_ctrl gpio_ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .gpio_req   (gpio_req),
    .bus_wen    (bus_wen),
    .reg_ofs    (bus_adr[`SOC_GPIO_BIT-1:0]),
    .bus_ben    (bus_ben),
    .bus_wdt    (bus_wdt),
    .gpio_rdt   (gpio_rdt),
    .gpio_drive (gpio_drive),
    .gpio_oe    (gpio_oe),
    .gpio_pin   (gpio_pin)
  );

  //////////////////////////////////////////
  // output side
  //////////////////////////////////////////

  rsp_mux rsp_mux_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_vld     (bus_vld),
    .bus_wen     (bus_wen),
    .target      (target),
    .mem_rdt     (mem_rdt),
    .gpio_rdt    (gpio_rdt),
    .bus_rsp_vld (bus_rsp_vld),
    .bus_rdt     (bus_rdt),
    .bus_err     (bus_err)
  );

endmodule : soc_top

/* verif/soc_props.sv */
/*
 * response timing properties of the soc data side
 * bound to soc_top
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_props (
  input logic                clk,
  input logic                rst_n,
  input logic                bus_vld,
  input logic                bus_wen,
  input logic                bus_rsp_vld,
  input logic [`SOC_DDW-1:0] bus_rdt,
  input logic                bus_err,
  input logic [`SOC_GW-1:0]  gpio_drive,
  input logic [`SOC_GW-1:0]  gpio_oe
);

  // every accepted request answered one cycle later
  a_rsp_after_req : assert property (@(posedge clk) disable iff (!rst_n)
    bus_vld |=> bus_rsp_vld)
    else $error("response missing one cycle after a request");

  // no response without a request
  a_no_rsp_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !bus_vld |=> !bus_rsp_vld)
    else $error("response without a request");

  // err only on a valid response
  a_err_in_rsp : assert property (@(posedge clk) bus_err |-> bus_rsp_vld)
    else $error("bus_err outside a response");

  // writes carry no read data
  a_wr_zero : assert property (@(posedge clk) disable iff (!rst_n)
    bus_vld && bus_wen |=> bus_rdt == '0)
    else $error("nonzero read data on a write response");

  // quiet outputs right after reset
  a_reset_state : assert property (@(posedge clk)
    $rose(rst_n) |-> !bus_rsp_vld && !bus_err && gpio_drive == '0 && gpio_oe == '0)
    else $error("outputs not cleared by reset");

endmodule : soc_props

bind soc_top soc_props soc_props_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .bus_vld     (bus_vld),
  .bus_wen     (bus_wen),
  .bus_rsp_vld (bus_rsp_vld),
  .bus_rdt     (bus_rdt),
  .bus_err     (bus_err),
  .gpio_drive  (gpio_drive),
  .gpio_oe     (gpio_oe)
);

/* verif/tb_clk.sv */
/*
 * testbench clock and reset
 * 10 ns clock, rst_n low for the first two cycles
 */
`timescale 1ns/1ps

module tb_clk (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clk

/* verif/tb_top.sv */
/*
 * soc data side testbench
 * table of requests with expected responses, driven back to back
 */
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_top;

  typedef struct {
    logic                wen;
    logic [`SOC_DAW-1:0] adr;
    logic [`SOC_DBW-1:0] ben;
    logic [`SOC_DDW-1:0] wdt;
    logic [`SOC_DDW-1:0] rdt;
    logic                err;
    // pin registers once this row has taken effect
    logic [`SOC_GW-1:0]  drv;
    logic [`SOC_GW-1:0]  oe;
  } row_t;

  logic clk, rst_n;
  logic bus_vld, bus_wen, bus_rsp_vld, bus_err;
  logic [`SOC_DAW-1:0] bus_adr;
  logic [`SOC_DBW-1:0] bus_ben;
  logic [`SOC_DDW-1:0] bus_wdt, bus_rdt;
  logic [`SOC_GW-1:0]  gpio_drive, gpio_oe, gpio_pin;

  row_t                rows[$];
  // reference model of memory and gpio registers
  logic [`SOC_DDW-1:0] mem_model[int];
  logic [`SOC_GW-1:0]  drv_model, oe_model, pin_val;
  logic [31:0]         lfsr;

  tb_clk tb_clk_i (.clk(clk), .rst_n(rst_n));

  soc_top dut_i (
    .clk(clk), .rst_n(rst_n), .bus_vld(bus_vld), .bus_wen(bus_wen), .bus_adr(bus_adr),
    .bus_ben(bus_ben), .bus_wdt(bus_wdt), .bus_rsp_vld(bus_rsp_vld), .bus_rdt(bus_rdt),
    .bus_err(bus_err), .gpio_drive(gpio_drive), .gpio_oe(gpio_oe), .gpio_pin(gpio_pin)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // galois lfsr, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_v, input logic [31:0] new_v,
                                              input logic [3:0] ben);
    logic [31:0] v;
    v = old_v;
    for (int i = 0; i < 4; i++) begin
      if (ben[i]) v[8*i +: 8] = new_v[8*i +: 8];
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // expected response from the address map rules
  task automatic add_row(input logic wen, input logic [`SOC_DAW-1:0] adr,
                         input logic [3:0] ben, input logic [31:0] wdt);
    row_t r;
    int   w;
    r = '{wen: wen, adr: adr, ben: ben, wdt: wdt, rdt: '0, err: 1'b0, drv: '0, oe: '0};
    w = adr[13:2];
    if (!adr[`SOC_PER_BIT]) begin
      if (wen) mem_model[w] = merge_bytes(mem_model.exists(w) ? mem_model[w] : '0, wdt, ben);
      else r.rdt = mem_model[w];
    end else if (adr[`SOC_GPIO_BIT]) begin
      r.err = 1'b1;
    end else begin
      case (adr[5:0])
        `SOC_GPIO_OFS_OUT: if (wen) drv_model = merge_bytes(drv_model, wdt, ben);
                           else r.rdt = drv_model;
        `SOC_GPIO_OFS_OE:  if (wen) oe_model = merge_bytes(oe_model, wdt, ben);
                           else r.rdt = oe_model;
        `SOC_GPIO_OFS_IN:  if (!wen) r.rdt = pin_val;
        default:           r.rdt = '0;
      endcase
    end
    r.drv = drv_model;
    r.oe  = oe_model;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // words written back to back, then read
    add_row(1, 15'h0000, 4'hf, rand_bits(32));
    add_row(1, 15'h0004, 4'hf, rand_bits(32));
    add_row(1, 15'h0010, 4'hf, rand_bits(32));
    add_row(1, 15'h3ffc, 4'hf, rand_bits(32));
    add_row(0, 15'h0000, 4'hf, '0);
    add_row(0, 15'h3ffc, 4'hf, '0);
    // single byte lanes over old data
    add_row(1, 15'h0004, 4'b0001, rand_bits(32));
    add_row(1, 15'h0010, 4'b0100, rand_bits(32));
    add_row(0, 15'h0004, 4'hf, '0);
    add_row(0, 15'h0010, 4'hf, '0);
    // gpio registers
    add_row(1, 15'h4000, 4'hf, rand_bits(32));
    add_row(1, 15'h4004, 4'b0011, rand_bits(32));
    add_row(1, 15'h4000, 4'b1000, rand_bits(32));
    add_row(0, 15'h4000, 4'hf, '0);
    add_row(0, 15'h4004, 4'hf, '0);
    add_row(0, 15'h4008, 4'hf, '0);
    add_row(0, 15'h400c, 4'hf, '0);
    // unmapped region, then memory right behind
    add_row(1, 15'h4040, 4'hf, rand_bits(32));
    add_row(0, 15'h4044, 4'hf, '0);
    add_row(1, 15'h7ffc, 4'hf, rand_bits(32));
    add_row(0, 15'h0000, 4'hf, '0);
  endtask

  ////////////////////////////////////////
  // run
  ////////////////////////////////////////

  initial begin
    int tmo;
    bus_vld  = 1'b0;
    bus_wen  = 1'b0;
    bus_adr  = '0;
    bus_ben  = '0;
    bus_wdt  = '0;
    gpio_pin = '0;
    lfsr      = 32'ha745;
    drv_model = '0;
    oe_model  = '0;
    pin_val   = rand_bits(32);
    build_table();
    // rst_n moves on falling edges, so look at it on rising ones
    tmo = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      tmo++;
      if (tmo > 20) begin
        $display("reset was not released within 20 cycles");
        $display(">>> FAIL");
        $fatal(1, "reset timeout");
      end
    end
    @(negedge clk);
    check_val("bus_rsp_vld", bus_rsp_vld, 1'b0);
    check_val("bus_err", bus_err, 1'b0);
    check_val("gpio_drive", gpio_drive, '0);
    check_val("gpio_oe", gpio_oe, '0);
    // pin settles long before the REG_IN read
    gpio_pin = pin_val;
    for (int i = 0; i <= rows.size(); i++) begin
      if (i > 0) begin
        check_val("bus_rsp_vld", bus_rsp_vld, 1'b1);
        check_val("bus_rdt", bus_rdt, rows[i-1].rdt);
        check_val("bus_err", bus_err, rows[i-1].err);
        check_val("gpio_drive", gpio_drive, rows[i-1].drv);
        check_val("gpio_oe", gpio_oe, rows[i-1].oe);
      end
      bus_vld = (i < rows.size());
      if (i < rows.size()) begin
        bus_wen = rows[i].wen;
        bus_adr = rows[i].adr;
        bus_ben = rows[i].ben;
        bus_wdt = rows[i].wdt;
      end
      @(negedge clk);
    end
    // nothing after the last response
    check_val("bus_rsp_vld", bus_rsp_vld, 1'b0);
    $display(">>> PASS");
    $finish;
  end

endmodule : tb_top

/* src.f */
+incdir+common
common/soc_pkg.sv
hdl/bus_decoder.sv
mem/data_mem.sv
gpio/gpio_ctrl.sv
hdl/rsp_mux.sv
hdl/soc_top.sv
verif/soc_props.sv
verif/tb_clk.sv
verif/tb_top.sv
